// File: Makefile
VERILATOR ?= verilator
TOP       ?= int_unit_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/int_pkg.sv
package int_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Entry sequencer state encoding
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_LATCH     = 3'd1,
    ST_WAIT_DEC  = 3'd2,
    ST_MEM_REQ   = 3'd3,
    ST_WAIT_DATA = 3'd4,
    ST_DONE      = 3'd5
  } int_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes and vector table
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_LINES_DEF = 8;  // Interrupt request lines.
  localparam int ADDR_W        = 32; // Memory and handler address width.
  localparam int CREDITS_DEF   = 2;  // Redirects in flight to fetch.

  // Entry for line i sits at base + 4*i.
  localparam logic [ADDR_W-1:0] VEC_TABLE_BASE = 32'h0000_0400;

endpackage

// File: design/int_redirect_out.sv
`timescale 1ns/1ps

module int_redirect_out import int_pkg::*; #(
  parameter  int credits = CREDITS_DEF,
  localparam int cnt_w   = $clog2(credits + 1)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_wait_data,
  input  logic              mem_dp_valid,
  input  logic [ADDR_W-1:0] mem_rdata,
  input  logic              credit_return,
  output logic              redirect_valid,
  output logic [ADDR_W-1:0] redirect_addr,
  output logic              has_credit
);

  localparam logic [cnt_w-1:0] CNT_FULL = cnt_w'(credits);

  logic             send;
  logic [cnt_w-1:0] credit_cnt;

  assign send       = in_wait_data && mem_dp_valid; // Handler word arrives.
  assign has_credit = (credit_cnt != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Redirect pulse and address
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      redirect_addr <= mem_rdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= CNT_FULL;
    end else begin
      case ({send, credit_return})
        2'b10:   if (credit_cnt != '0) credit_cnt <= credit_cnt - 1'b1;
        2'b01:   if (credit_cnt != CNT_FULL) credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt; // Both or neither.
      endcase
    end
  end

endmodule

// File: design/int_request_latch.sv
`timescale 1ns/1ps

module int_request_latch import int_pkg::*; #(
  parameter  int num_lines = NUM_LINES_DEF,
  localparam int idx_w     = (num_lines > 1) ? $clog2(num_lines) : 1
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [num_lines-1:0] irq,
  input  logic                 int_ack,
  input  logic                 has_credit,
  output logic                 or_int_vec,
  output logic [idx_w-1:0]     sel_index
);

  logic [num_lines-1:0] pending;
  logic [num_lines-1:0] ack_mask;
  logic [idx_w-1:0]     pick;

  ////////////////////////////////////////////////////////////////////////////
  // Priority pick with the lowest index first
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    pick = '0;
    for (int i = num_lines - 1; i >= 0; i--) begin
      if (pending[i]) begin
        pick = idx_w'(i);
      end
    end
  end

  assign ack_mask   = int_ack ? (num_lines'(1) << pick) : '0;
  assign or_int_vec = (|pending) && has_credit; // Start only with a credit.

  ////////////////////////////////////////////////////////////////////////////
  // Pending bits and frozen selection
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~ack_mask) | irq; // Pulse in ack cycle kept.
    end
  end

  // Held for the whole entry and feeds the table address.
  always_ff @(posedge clk) begin
    if (reset) begin
      sel_index <= '0;
    end else if (int_ack) begin
      sel_index <= pick;
    end
  end

endmodule

// File: design/int_unit_top.sv
`timescale 1ns/1ps

module int_unit_top import int_pkg::*; #(
  parameter  int num_lines = NUM_LINES_DEF,
  parameter  int credits   = CREDITS_DEF,
  localparam int idx_w     = (num_lines > 1) ? $clog2(num_lines) : 1
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [num_lines-1:0] irq,
  input  logic                 dec_end,
  input  logic                 mem_ready,
  input  logic [ADDR_W-1:0]    mem_rdata,
  input  logic                 mem_dp_valid,
  input  logic                 credit_return,
  output logic                 mem_req,
  output logic [ADDR_W-1:0]    mem_addr,
  output logic                 redirect_valid,
  output logic [ADDR_W-1:0]    redirect_addr
);

  logic             or_int_vec;
  logic [idx_w-1:0] sel_index;
  logic             int_ack;
  logic             has_credit;
  logic             in_wait_data;

  // Vector table entry of the selected line.
  assign mem_addr = VEC_TABLE_BASE + (ADDR_W'(sel_index) << 2);

  int_request_latch #(
    .num_lines (num_lines)
  ) u_request_latch (
    .clk        (clk),
    .reset      (reset),
    .irq        (irq),
    .int_ack    (int_ack),
    .has_credit (has_credit),
    .or_int_vec (or_int_vec),
    .sel_index  (sel_index)
  );

  int_sequencer u_sequencer (
    .clk          (clk),
    .reset        (reset),
    .or_int_vec   (or_int_vec),
    .dec_end      (dec_end),
    .mem_ready    (mem_ready),
    .mem_dp_valid (mem_dp_valid),
    .int_ack      (int_ack),
    .mem_req      (mem_req),
    .in_wait_data (in_wait_data)
  );

  int_redirect_out #(
    .credits (credits)
  ) u_redirect_out (
    .clk            (clk),
    .reset          (reset),
    .in_wait_data   (in_wait_data),
    .mem_dp_valid   (mem_dp_valid),
    .mem_rdata      (mem_rdata),
    .credit_return  (credit_return),
    .redirect_valid (redirect_valid),
    .redirect_addr  (redirect_addr),
    .has_credit     (has_credit)
  );

endmodule

// File: flist.f
common/int_pkg.sv
design/int_request_latch.sv
int_sequencer/int_next_state_cloud.sv
int_sequencer/int_sequencer.sv
design/int_redirect_out.sv
design/int_unit_top.sv
sim/int_unit_checker.sv
sim/int_unit_sva.sv
sim/int_unit_tb.sv

// File: int_sequencer/int_next_state_cloud.sv
`timescale 1ns/1ps

module int_next_state_cloud import int_pkg::*; (
  input  int_state_t curr_state,
  input  logic       or_int_vec,
  input  logic       dec_end_int,
  input  logic       mem_ready,
  input  logic       mem_dp_valid,
  output int_state_t next_state
);

  always_comb begin
    case (curr_state)
      ST_IDLE: begin
        next_state = or_int_vec ? ST_LATCH : ST_IDLE;
      end
      ST_LATCH: begin
        next_state = ST_WAIT_DEC;
      end
      ST_WAIT_DEC: begin
        next_state = dec_end_int ? ST_MEM_REQ : ST_WAIT_DEC; // Instruction boundary.
      end
      ST_MEM_REQ: begin
        next_state = mem_ready ? ST_WAIT_DATA : ST_MEM_REQ;
      end
      ST_WAIT_DATA: begin
        next_state = mem_dp_valid ? ST_DONE : ST_WAIT_DATA;
      end
      ST_DONE: begin
        next_state = ST_IDLE;
      end
      default: begin
        next_state = ST_IDLE; // Codes 6 and 7.
      end
    endcase
  end

endmodule

// File: int_sequencer/int_sequencer.sv
`timescale 1ns/1ps

module int_sequencer import int_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic or_int_vec,
  input  logic dec_end,
  input  logic mem_ready,
  input  logic mem_dp_valid,
  output logic int_ack,
  output logic mem_req,
  output logic in_wait_data
);

  int_state_t curr_state;
  int_state_t next_state;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  int_next_state_cloud u_next_state (
    .curr_state   (curr_state),
    .or_int_vec   (or_int_vec),
    .dec_end_int  (dec_end),
    .mem_ready    (mem_ready),
    .mem_dp_valid (mem_dp_valid),
    .next_state   (next_state)
  );

  ////////////////////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      curr_state <= ST_IDLE;
    end else begin
      curr_state <= next_state;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output decode
  ////////////////////////////////////////////////////////////////////////////

  // Moore outputs decoded from the state alone.
  always_comb begin
    int_ack      = 1'b0;
    mem_req      = 1'b0;
    in_wait_data = 1'b0;
    case (curr_state)
      ST_LATCH: begin
        int_ack = 1'b1; // Latch clears the picked bit.
      end
      ST_MEM_REQ: begin
        mem_req = 1'b1; // Held until mem_ready.
      end
      ST_WAIT_DATA: begin
        in_wait_data = 1'b1;
      end
      default: begin
        int_ack = 1'b0;
      end
    endcase
  end

endmodule

// File: sim/int_unit_checker.sv
`timescale 1ns/1ps

module int_unit_checker import int_pkg::*; #(
  parameter int num_lines = NUM_LINES_DEF
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 redirect_valid,
  input  logic [ADDR_W-1:0]    redirect_addr,
  input  logic [num_lines-1:0] exp_mask,
  input  logic [8*12-1:0]      test_name,
  output int                   checks,
  output int                   errors,
  output int                   outstanding
);

  int exp_q[$]; // Lines in expected redirect order.
  int check_cnt = 0;
  int error_cnt = 0;
  int pend_cnt  = 0;

  assign checks      = check_cnt;
  assign errors      = error_cnt;
  assign outstanding = pend_cnt;

  // Table entry of the line, then the handler word the memory holds there.
  function automatic logic [ADDR_W-1:0] handler_of(input int line);
    logic [ADDR_W-1:0] entry;
    entry = VEC_TABLE_BASE + ADDR_W'(4 * line);
    return {entry[ADDR_W-1:16] ^ 16'hC0DE, entry[15:0]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare every redirect with the head of the queue
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    int                line;
    logic [ADDR_W-1:0] expected;
    if (reset) begin
      if (exp_q.size() != 0) begin
        $display("Reset in %0s dropped %0d expected redirects", test_name, exp_q.size());
        error_cnt++;
        exp_q.delete();
      end
    end else begin
      for (int i = 0; i < num_lines; i++) begin
        if (exp_mask[i]) begin
          exp_q.push_back(i); // Ascending index is the priority order.
        end
      end
      if (redirect_valid && exp_q.size() == 0) begin
        $display("Redirect to %h in %0s with no request outstanding", redirect_addr, test_name);
        error_cnt++;
      end else if (redirect_valid) begin
        line     = exp_q.pop_front();
        expected = handler_of(line);
        check_cnt++;
        if (redirect_addr !== expected) begin
          $display("FAILED %0s: line %0d expected %h actual %h",
                   test_name, line, expected, redirect_addr);
          error_cnt++;
        end
      end
    end
    pend_cnt = exp_q.size();
  end

endmodule

// File: sim/int_unit_sva.sv
`timescale 1ns/1ps

module int_unit_sva import int_pkg::*; (
  input logic              clk,
  input logic              reset,
  input logic              mem_req,
  input logic              mem_ready,
  input logic [ADDR_W-1:0] mem_addr,
  input logic              redirect_valid,
  input logic              has_credit
);

  a_addr_stable : assert property (@(posedge clk) disable iff (reset)
    mem_req && !mem_ready |=> mem_req && $stable(mem_addr))
    else $error("mem_addr moved while mem_req waited for mem_ready");

  // Count drops at the same edge that raises redirect_valid.
  a_credit : assert property (@(posedge clk) disable iff (reset)
    redirect_valid |-> $past(has_credit))
    else $error("redirect_valid sent without a credit");

  a_one_cycle : assert property (@(posedge clk) disable iff (reset)
    redirect_valid |=> !redirect_valid)
    else $error("redirect_valid held for two cycles");

  a_reset_idle : assert property (@(posedge clk) reset |=> !mem_req)
    else $error("mem_req high in the cycle after reset");

endmodule

bind int_unit_top int_unit_sva u_sva (
  .clk            (clk),
  .reset          (reset),
  .mem_req        (mem_req),
  .mem_ready      (mem_ready),
  .mem_addr       (mem_addr),
  .redirect_valid (redirect_valid),
  .has_credit     (has_credit)
);

// File: sim/int_unit_tb.sv
`timescale 1ns/1ps

module int_unit_tb import int_pkg::*; ();

  localparam int num_lines = NUM_LINES_DEF;
  localparam int credits   = CREDITS_DEF;

  logic                 clk           = 1'b0;
  logic                 reset         = 1'b1;
  logic [num_lines-1:0] irq           = '0;
  logic                 dec_end       = 1'b1;
  logic                 mem_ready     = 1'b0;
  logic                 mem_dp_valid  = 1'b0;
  logic [ADDR_W-1:0]    mem_rdata     = '0;
  logic                 credit_return = 1'b0;
  logic                 mem_req;
  logic                 redirect_valid;
  logic [ADDR_W-1:0]    mem_addr;
  logic [ADDR_W-1:0]    redirect_addr;
  logic [num_lines-1:0] exp_mask      = '0;
  logic [8*12-1:0]      test_name     = "reset";
  logic                 hold_credits  = 1'b0;
  logic [ADDR_W-1:0]    mem_lat_addr  = '0;
  int                   checks;
  int                   chk_errors;
  int                   outstanding;
  int                   tb_errors     = 0;
  int                   seed          = 32'h15a3;
  int                   owed          = 0; // Redirects fetch has not returned.
  int                   ret_wait      = 0;
  int                   mem_phase     = 0;
  int                   mem_wait      = 0;

  always #20 clk = ~clk;

  int_unit_top #(
    .num_lines (num_lines),
    .credits   (credits)
  ) DUT (
    .clk            (clk),
    .reset          (reset),
    .irq            (irq),
    .dec_end        (dec_end),
    .mem_ready      (mem_ready),
    .mem_rdata      (mem_rdata),
    .mem_dp_valid   (mem_dp_valid),
    .credit_return  (credit_return),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .redirect_valid (redirect_valid),
    .redirect_addr  (redirect_addr)
  );

  int_unit_checker #(
    .num_lines (num_lines)
  ) u_checker (
    .clk            (clk),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_addr  (redirect_addr),
    .exp_mask       (exp_mask),
    .test_name      (test_name),
    .checks         (checks),
    .errors         (chk_errors),
    .outstanding    (outstanding)
  );

  function automatic int rand_below(input int n);
    int unsigned r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory and fetch stage models
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    #2;
    mem_ready    = 1'b0;
    mem_dp_valid = 1'b0;
    if (reset) begin
      mem_phase = 0;
    end else begin
      if (mem_phase == 0 && mem_req) begin
        mem_wait  = rand_below(4); // Ready delay 0 to 3.
        mem_phase = 1;
      end
      if (mem_phase == 1) begin
        if (mem_wait == 0) begin
          mem_ready    = 1'b1;
          mem_lat_addr = mem_addr;
          mem_wait     = rand_below(4); // Data 1 to 4 cycles later.
          mem_phase    = 2;
        end else begin
          mem_wait--;
        end
      end else if (mem_phase == 2) begin
        if (mem_wait == 0) begin
          mem_dp_valid = 1'b1;
          mem_rdata    = {mem_lat_addr[ADDR_W-1:16] ^ 16'hC0DE, mem_lat_addr[15:0]};
          mem_phase    = 0;
        end else begin
          mem_wait--;
        end
      end
    end
  end

  always @(posedge clk) begin
    #2;
    credit_return = 1'b0;
    if (reset) begin
      owed = 0;
    end else begin
      if (redirect_valid) begin
        owed++;
      end
      if (owed > 0 && !hold_credits) begin
        if (ret_wait == 0) begin
          credit_return = 1'b1;
          owed--;
          ret_wait = rand_below(4);
        end else begin
          ret_wait--;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic pulse(input logic [num_lines-1:0] mask, input bit expect_redirect);
    step();
    irq      = mask;
    exp_mask = expect_redirect ? mask : '0;
    step();
    irq      = '0;
    exp_mask = '0;
  endtask

  task automatic finish_run();
    $display("Summary: %0d redirects checked, %0d checker errors, %0d testbench errors",
             checks, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (outstanding != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (outstanding != 0) begin
      $display("Timeout in %0s: %0d redirects never arrived", test_name, outstanding);
      tb_errors++;
      finish_run();
    end
  endtask

  task automatic wait_checks(input int target, input int limit);
    int n;
    n = 0;
    while (checks < target && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (checks < target) begin
      $display("Timeout in %0s: only %0d of %0d redirects seen", test_name, checks, target);
      tb_errors++;
      finish_run();
    end
  endtask

  task automatic wait_credits_home(input int limit);
    int n;
    n = 0;
    while (owed != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (owed != 0) begin
      $display("Timeout in %0s: fetch model kept %0d credits", test_name, owed);
      tb_errors++;
      finish_run();
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (mem_req || redirect_valid) begin
        $display("Unexpected activity in %0s: mem_req=%b redirect_valid=%b",
                 test_name, mem_req, redirect_valid);
        tb_errors++;
      end
    end
  endtask

  initial begin
    logic [num_lines-1:0] mask;
    int                   base;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    expect_quiet(10);

    test_name = "single";
    for (int i = 0; i < num_lines; i++) begin
      pulse(num_lines'(1) << i, 1'b1);
      wait_drained(100);
    end

    test_name = "priority";
    pulse(num_lines'(8'hA6), 1'b1);
    wait_drained(300);

    test_name = "boundary";
    step();
    dec_end = 1'b0;
    pulse(num_lines'(8'h08), 1'b1);
    expect_quiet(25); // No table read before the boundary.
    step();
    dec_end = 1'b1;
    wait_drained(100);

    test_name = "credits";
    wait_credits_home(100);
    hold_credits = 1'b1;
    base         = checks;
    pulse(num_lines'(8'h1F), 1'b1);
    wait_checks(base + credits, 200);
    expect_quiet(30);
    if (checks != base + credits) begin
      $display("FAILED %0s: expected %0d redirects actual %0d",
               test_name, credits, checks - base);
      tb_errors++;
    end
    hold_credits = 1'b0;
    wait_drained(400);

    test_name = "latency";
    repeat (12) begin
      mask = num_lines'(rand_below(1 << num_lines));
      if (mask == '0) begin
        mask = num_lines'(1);
      end
      pulse(mask, 1'b1);
      wait_drained(600);
    end

    test_name = "midreset";
    step();
    dec_end = 1'b0;
    pulse(num_lines'(8'h81), 1'b0); // Lost to the reset below.
    step();
    reset = 1'b1;
    repeat (3) step();
    reset   = 1'b0;
    dec_end = 1'b1;
    expect_quiet(30);
    pulse(num_lines'(8'h04), 1'b1);
    wait_drained(100);
    finish_run();
  end

endmodule
